// ==== mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

    localparam int BYTE_LANES = 4;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Access width and signedness, encoded like funct3 of loads and stores
    typedef enum logic [2:0] {
        LB   = 3'b000,
        LH   = 3'b001,
        LW   = 3'b010,
        LBU  = 3'b100,
        LHU  = 3'b101,
        NONE = 3'b111
    } mem_width_t;

    // Source of the register writeback value
    typedef enum logic [2:0] {
        W_SEL_FROM_DLOAD = 3'd0,
        W_SEL_FROM_PC    = 3'd1,
        W_SEL_FROM_IMM_U = 3'd2,
        W_SEL_FROM_ALU   = 3'd3
    } w_sel_t;

    // Executed instruction handed over by the execute stage
    typedef struct packed {
        logic       valid;
        word_t      pc4;
        word_t      port_out;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      imm_u;
        reg_idx_t   rd;
        logic       reg_write;
        logic       dren;
        logic       dwen;
        mem_width_t width;
        w_sel_t     w_sel;
        logic       ifence;
        logic       sfence;
        logic       halt;
    } ex_mem_t;

    // Single-cycle data bus request
    typedef struct packed {
        word_t                 addr;
        word_t                 wdata;
        logic [BYTE_LANES-1:0] byte_en;
        logic                  ren;
        logic                  wen;
    } dbus_req_t;

    typedef struct packed {
        logic mal_l;
        logic mal_s;
        logic fault_l;
        logic fault_s;
    } mem_exc_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t rd;
        word_t    reg_wdata;
        logic     halt;
        mem_exc_t exc;
    } mem_wb_t;

    // Value offered to the forwarding unit
    typedef struct packed {
        reg_idx_t rd;
        logic     reg_write;
        word_t    data;
    } fwd_t;

endpackage

`default_nettype wire

// ==== pipe_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

// Pipeline register shared by the ex/mem and mem/wb slots.
// An all-zero payload is a bubble, since valid is then low.
module pipe_reg #(
    parameter type PAYLOAD_T = logic [31:0]
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     hold,
    input  logic     bubble,
    input  PAYLOAD_T d,
    output PAYLOAD_T q
);

    PAYLOAD_T q_next;

    // Hold wins over bubble so a stalled slot keeps its instruction
    always_comb begin
        if (hold) begin
            q_next = q;
        end else if (bubble) begin
            q_next = '0;
        end else begin
            q_next = d;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            q <= '0;
        end else begin
            q <= q_next;
        end
    end

endmodule

`default_nettype wire

// ==== mem_lane_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_lane_unit
    import mem_stage_pkg::*;
(
    input  ex_mem_t   ex,
    input  logic      dbus_error,
    output dbus_req_t dbus,
    output mem_exc_t  exc
);

    logic [1:0]            offset;
    logic                  mal_addr;
    logic [BYTE_LANES-1:0] lane_map;
    word_t                 store_data;

    assign offset = ex.port_out[1:0];

    // Natural alignment per access width
    always_comb begin
        case (ex.width)
            LW:      mal_addr = (offset != 2'b00);
            LH, LHU: mal_addr = offset[0];
            default: mal_addr = 1'b0;
        endcase
    end

    // Little-endian lane map, empty for a misaligned access
    always_comb begin
        case (ex.width)
            LB, LBU: lane_map = 4'b0001 << offset;
            LH, LHU: begin
                if (offset[0]) begin
                    lane_map = 4'b0000;
                end else begin
                    lane_map = offset[1] ? 4'b1100 : 4'b0011;
                end
            end
            LW:      lane_map = mal_addr ? 4'b0000 : 4'b1111;
            default: lane_map = 4'b0000;
        endcase
    end

    // Store data copied to every lane the access may hit
    always_comb begin
        case (ex.width)
            LB, LBU: store_data = {4{ex.rs2_data[7:0]}};
            LH, LHU: store_data = {2{ex.rs2_data[15:0]}};
            LW:      store_data = ex.rs2_data;
            default: store_data = '0;
        endcase
    end

    assign dbus.addr    = ex.port_out;
    assign dbus.wdata   = store_data;
    assign dbus.byte_en = lane_map;
    assign dbus.ren     = ex.valid && ex.dren && !mal_addr;
    assign dbus.wen     = ex.valid && ex.dwen && !mal_addr;

    assign exc.mal_l   = ex.valid && ex.dren && mal_addr;
    assign exc.mal_s   = ex.valid && ex.dwen && mal_addr;
    assign exc.fault_l = dbus.ren && dbus_error;
    assign exc.fault_s = dbus.wen && dbus_error;

    // Execute stage never marks one instruction as both load and store
    always_comb begin
        a_strobe_excl: assert final (!(dbus.ren && dbus.wen))
            else $error("ren and wen both high");
        a_lanes_on_strobe: assert final (!(dbus.ren || dbus.wen) || (dbus.byte_en != '0))
            else $error("strobe with empty byte_en");
    end

endmodule

`default_nettype wire

// ==== load_extender.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_extender
    import mem_stage_pkg::*;
(
    input  word_t      rdata,
    input  mem_width_t width,
    input  logic [1:0] offset,
    output word_t      ext
);

    word_t shifted;

    // Addressed byte or half-word moved down to bit 0
    assign shifted = rdata >> {offset, 3'b000};

    always_comb begin
        case (width)
            LB:      ext = {{24{shifted[7]}}, shifted[7:0]};
            LBU:     ext = {24'h000000, shifted[7:0]};
            LH:      ext = {{16{shifted[15]}}, shifted[15:0]};
            LHU:     ext = {16'h0000, shifted[15:0]};
            LW:      ext = rdata;
            default: ext = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== fence_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module fence_tracker (
    input  logic CLK,
    input  logic nRST,
    input  logic ifence,
    input  logic sfence,
    input  logic iflush_done,
    input  logic dflush_done,
    input  logic itlb_done,
    input  logic dtlb_done,
    output logic icache_flush,
    output logic dcache_flush,
    output logic itlb_fence,
    output logic dtlb_fence,
    output logic fence_stall
);

    // Bit 0 is the cache fence, bit 1 the TLB fence
    logic [1:0] fence_lvl;
    logic [1:0] fence_prev;
    logic [1:0] fence_pulse;
    logic [1:0] done_i;
    logic [1:0] done_d;
    logic [1:0] flag_i;
    logic [1:0] flag_d;
    logic [1:0] flag_i_next;
    logic [1:0] flag_d_next;

    assign fence_lvl   = {sfence, ifence};
    assign done_i      = {itlb_done, iflush_done};
    assign done_d      = {dtlb_done, dflush_done};
    assign fence_pulse = fence_lvl & ~fence_prev;

    // Flags drop on the pulse, come back with the done pulse
    assign flag_i_next = (flag_i & ~fence_pulse) | done_i;
    assign flag_d_next = (flag_d & ~fence_pulse) | done_d;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fence_prev <= 2'b00;
            flag_i     <= 2'b11;
            flag_d     <= 2'b11;
        end else begin
            fence_prev <= fence_lvl;
            flag_i     <= flag_i_next;
            flag_d     <= flag_d_next;
        end
    end

    assign icache_flush = fence_pulse[0];
    assign dcache_flush = fence_pulse[0];
    assign itlb_fence   = fence_pulse[1];
    assign dtlb_fence   = fence_pulse[1];

    // Release in the cycle the last done pulse shows up
    assign fence_stall = |(fence_lvl & ~(flag_i_next & flag_d_next));

    a_no_pulse_in_stall: assert property (@(posedge CLK) disable iff (!nRST)
        (|fence_pulse) |-> !$past(fence_stall))
        else $error("fence pulse while a fence is still pending");

endmodule

`default_nettype wire

// ==== wb_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_select
    import mem_stage_pkg::*;
(
    input  ex_mem_t  ex,
    input  word_t    load_data,
    input  mem_exc_t exc,
    output mem_wb_t  wb,
    output fwd_t     fwd
);

    word_t wdata;
    word_t fwd_data;
    logic  write_ok;

    always_comb begin
        case (ex.w_sel)
            W_SEL_FROM_DLOAD: wdata = load_data;
            W_SEL_FROM_PC:    wdata = ex.pc4;
            W_SEL_FROM_IMM_U: wdata = ex.imm_u;
            W_SEL_FROM_ALU:   wdata = ex.port_out;
            default:          wdata = '0;
        endcase
    end

    // Load data is not ready in time for forwarding, loads offer zero
    always_comb begin
        case (ex.w_sel)
            W_SEL_FROM_PC:    fwd_data = ex.pc4;
            W_SEL_FROM_IMM_U: fwd_data = ex.imm_u;
            W_SEL_FROM_ALU:   fwd_data = ex.port_out;
            default:          fwd_data = '0;
        endcase
    end

    // Any memory exception kills the register write
    assign write_ok = ex.valid && ex.reg_write && !(|exc);

    assign wb.valid     = ex.valid;
    assign wb.reg_write = write_ok;
    assign wb.rd        = ex.rd;
    assign wb.reg_wdata = wdata;
    assign wb.halt      = ex.halt;
    assign wb.exc       = exc;

    assign fwd.rd        = ex.rd;
    assign fwd.reg_write = write_ok;
    assign fwd.data      = fwd_data;

endmodule

`default_nettype wire

// ==== mem_pipeline_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_pipeline_top
    import mem_stage_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  ex_mem_t   ex_in,
    output dbus_req_t dbus,
    input  word_t     dbus_rdata,
    input  logic      dbus_busy,
    input  logic      dbus_error,
    output logic      icache_flush,
    output logic      dcache_flush,
    output logic      itlb_fence,
    output logic      dtlb_fence,
    input  logic      iflush_done,
    input  logic      dflush_done,
    input  logic      itlb_done,
    input  logic      dtlb_done,
    output logic      stall,
    output fwd_t      fwd,
    output mem_wb_t   wb_out
);

    ex_mem_t  ex_mem;
    mem_exc_t exc;
    word_t    load_ext;
    mem_wb_t  wb_next;
    logic     fence_stall;

    assign stall = dbus_busy || fence_stall;

    // ex/mem slot keeps its instruction while the stage stalls
    pipe_reg #(.PAYLOAD_T(ex_mem_t)) u_ex_mem_reg (
        .CLK(CLK), .nRST(nRST), .hold(stall), .bubble(1'b0), .d(ex_in), .q(ex_mem)
    );

    mem_lane_unit u_lanes (
        .ex(ex_mem), .dbus_error(dbus_error), .dbus(dbus), .exc(exc)
    );

    load_extender u_load_ext (
        .rdata(dbus_rdata), .width(ex_mem.width), .offset(ex_mem.port_out[1:0]),
        .ext(load_ext)
    );

    fence_tracker u_fences (
        .CLK(CLK), .nRST(nRST),
        .ifence(ex_mem.valid && ex_mem.ifence), .sfence(ex_mem.valid && ex_mem.sfence),
        .iflush_done(iflush_done), .dflush_done(dflush_done),
        .itlb_done(itlb_done), .dtlb_done(dtlb_done),
        .icache_flush(icache_flush), .dcache_flush(dcache_flush),
        .itlb_fence(itlb_fence), .dtlb_fence(dtlb_fence), .fence_stall(fence_stall)
    );

    wb_select u_wb_sel (
        .ex(ex_mem), .load_data(load_ext), .exc(exc), .wb(wb_next), .fwd(fwd)
    );

    // Stall cycles leave a bubble in the mem/wb slot
    pipe_reg #(.PAYLOAD_T(mem_wb_t)) u_mem_wb_reg (
        .CLK(CLK), .nRST(nRST), .hold(1'b0), .bubble(stall), .d(wb_next), .q(wb_out)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

// 4 ns clock, reset released 1 ns after the 16th rising edge
module tb_clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (16) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_mem_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_pipeline
    import mem_stage_pkg::*;
();

    // One line of the test file
    typedef struct packed {
        ex_mem_t    ex;
        word_t      rdata;
        logic [7:0] busy;
        logic       err;
        logic [7:0] delay;
        word_t      exp_wdata;
        logic [3:0] exp_be;
        logic       exp_ren;
        logic       exp_wen;
        mem_exc_t   exp_exc;
        word_t      exp_reg_wdata;
        logic       exp_rw;
    } test_t;

    // Result expected in wb_out, with the cycle it is due in
    typedef struct packed {
        logic [31:0] due;
        reg_idx_t    rd;
        word_t       wdata;
        logic        rw;
        logic        halt;
        mem_exc_t    exc;
    } wb_exp_t;

    logic      CLK;
    logic      nRST;
    ex_mem_t   ex_in;
    dbus_req_t dbus;
    word_t     dbus_rdata;
    logic      dbus_busy;
    logic      dbus_error;
    logic      icache_flush;
    logic      dcache_flush;
    logic      itlb_fence;
    logic      dtlb_fence;
    logic      iflush_done;
    logic      dflush_done;
    logic      itlb_done;
    logic      dtlb_done;
    logic      stall;
    fwd_t      fwd;
    mem_wb_t   wb_out;

    test_t       tests[$];
    wb_exp_t     wb_pending[$];
    int          num_tests;
    int          errors;
    int          checks;
    int          cycle_count;
    logic [31:0] rnd_state;

    tb_clock_gen u_clk (.CLK(CLK), .nRST(nRST));

    mem_pipeline_top u_dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_problem(input string msg);
        errors++;
        $display("%s at %0t ns", msg, $time);
    endtask

    task automatic compare_hex(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("ERR %s expected %h actual %h at %0t ns", name, exp_v, act_v, $time);
        end
    endtask

    task automatic drive_idle();
        dbus_rdata  = '0;
        dbus_busy   = 1'b0;
        dbus_error  = 1'b0;
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        itlb_done   = 1'b0;
        dtlb_done   = 1'b0;
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [23];
        test_t       t;
        fd = $fopen("mem_tests.txt", "r");
        if (fd == 0) begin
            report_problem("could not open mem_tests.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 4 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22]);
            if (n != 23) begin
                report_problem($sformatf("test line has %0d fields instead of 23", n));
                continue;
            end
            t               = '0;
            t.ex.valid      = 1'b1;
            t.ex.pc4        = f[0];
            t.ex.port_out   = f[1];
            t.ex.rs2_data   = f[2];
            t.ex.imm_u      = f[3];
            t.ex.rd         = f[4][4:0];
            t.ex.reg_write  = f[5][0];
            t.ex.dren       = f[6][0];
            t.ex.dwen       = f[7][0];
            t.ex.width      = mem_width_t'(f[8][2:0]);
            t.ex.w_sel      = w_sel_t'(f[9][2:0]);
            t.ex.ifence     = f[10][0];
            t.ex.sfence     = f[11][0];
            t.rdata         = f[12];
            t.busy          = f[13][7:0];
            t.err           = f[14][0];
            t.delay         = f[15][7:0];
            t.exp_wdata     = f[16];
            t.exp_be        = f[17][3:0];
            t.exp_ren       = f[18][0];
            t.exp_wen       = f[19][0];
            t.exp_exc       = f[20][3:0];
            t.exp_reg_wdata = f[21];
            t.exp_rw        = f[22][0];
            tests.push_back(t);
        end
        $fclose(fd);
        // The last instruction of the file ends the program
        if (tests.size() > 0) begin
            t         = tests.pop_back();
            t.ex.halt = 1'b1;
            tests.push_back(t);
        end
    endtask

    // Entered 1 ns after the edge that moved t into the memory stage
    task automatic run_stage(input test_t t, input ex_mem_t next);
        int      cyc;
        int      n_flush;
        int      n_tlb;
        logic    done_now;
        logic    exp_stall;
        word_t   exp_fwd;
        wb_exp_t w;
        cyc     = 0;
        n_flush = 0;
        n_tlb   = 0;
        ex_in   = next;
        // Loads offer zero to forwarding
        exp_fwd = (t.ex.w_sel == W_SEL_FROM_DLOAD) ? '0 : t.exp_reg_wdata;
        forever begin
            done_now    = (cyc == t.delay);
            dbus_rdata  = t.rdata;
            dbus_busy   = (cyc < t.busy);
            dbus_error  = t.err;
            iflush_done = t.ex.ifence && done_now;
            dflush_done = t.ex.ifence && done_now;
            itlb_done   = t.ex.sfence && done_now;
            dtlb_done   = t.ex.sfence && done_now;
            exp_stall   = (cyc < t.busy) || ((t.ex.ifence || t.ex.sfence) && cyc < t.delay);
            #2;
            compare_hex("dbus.addr", t.ex.port_out, dbus.addr);
            compare_hex("dbus.wdata", t.exp_wdata, dbus.wdata);
            compare_hex("dbus.byte_en", t.exp_be, dbus.byte_en);
            compare_hex("dbus.ren", t.exp_ren, dbus.ren);
            compare_hex("dbus.wen", t.exp_wen, dbus.wen);
            compare_hex("fwd.data", exp_fwd, fwd.data);
            compare_hex("fwd.reg_write", t.exp_rw, fwd.reg_write);
            compare_hex("fwd.rd", t.ex.rd, fwd.rd);
            compare_hex("stall", exp_stall, stall);
            if (icache_flush !== dcache_flush) begin
                report_problem("icache_flush and dcache_flush did not pulse together");
            end
            if (itlb_fence !== dtlb_fence) begin
                report_problem("itlb_fence and dtlb_fence did not pulse together");
            end
            n_flush += (icache_flush === 1'b1);
            n_tlb   += (itlb_fence === 1'b1);
            if (stall === 1'b0) begin
                break;
            end
            if (cyc > t.busy + t.delay + 4) begin
                report_problem("instruction stuck in the memory stage");
                break;
            end
            cyc++;
            @(posedge CLK);
            #1;
        end
        compare_hex("icache_flush pulses", t.ex.ifence, n_flush);
        compare_hex("itlb_fence pulses", t.ex.sfence, n_tlb);
        w.due   = cycle_count + 1;
        w.rd    = t.ex.rd;
        w.wdata = t.exp_reg_wdata;
        w.rw    = t.exp_rw;
        w.halt  = t.ex.halt;
        w.exc   = t.exp_exc;
        wb_pending.push_back(w);
        @(posedge CLK);
        #1;
        drive_idle();
    endtask

    initial begin : main
        ex_mem_t next;
        logic    bubble_next;
        int      i;
        ex_in     = '0;
        drive_idle();
        errors    = 0;
        checks    = 0;
        rnd_state = 32'd21155;
        load_tests();
        num_tests = tests.size();
        if (num_tests == 0) begin
            report_problem("no tests were loaded");
        end
        wait (nRST === 1'b1);
        @(posedge CLK);
        #1;
        if (num_tests > 0) begin
            ex_in = tests[0].ex;
            @(posedge CLK);
            #1;
        end
        for (i = 0; i < num_tests; i++) begin
            bubble_next = 1'b0;
            next        = '0;
            // Random bubbles only between lines
            if (i + 1 < num_tests) begin
                rnd_state   = xorshift32(rnd_state);
                bubble_next = (rnd_state[1:0] == 2'b00);
                if (!bubble_next) begin
                    next = tests[i + 1].ex;
                end
            end
            run_stage(tests[i], next);
            if (bubble_next) begin
                ex_in = tests[i + 1].ex;
                @(posedge CLK);
                #1;
            end
        end
        ex_in = '0;
        repeat (4) @(posedge CLK);
        if (wb_pending.size() != 0) begin
            report_problem($sformatf("%0d results never reached wb_out", wb_pending.size()));
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Results must leave in issue order, one cycle after release
    initial begin : wb_monitor
        wb_exp_t w;
        cycle_count = 0;
        forever begin
            @(posedge CLK);
            cycle_count++;
            #3;
            if (wb_out.valid === 1'b1) begin
                if (wb_pending.size() == 0) begin
                    report_problem("wb_out valid with no instruction pending");
                end else begin
                    w = wb_pending.pop_front();
                    if (w.due != cycle_count) begin
                        report_problem("wb_out result arrived in the wrong cycle");
                    end
                    compare_hex("wb_out.reg_wdata", w.wdata, wb_out.reg_wdata);
                    compare_hex("wb_out.reg_write", w.rw, wb_out.reg_write);
                    compare_hex("wb_out.rd", w.rd, wb_out.rd);
                    compare_hex("wb_out.halt", w.halt, wb_out.halt);
                    compare_hex("wb_out.exc", w.exc, wb_out.exc);
                end
            end
        end
    end

    initial begin : watchdog
        wait (num_tests > 0);
        repeat (num_tests * 64 + 200) @(posedge CLK);
        report_problem("watchdog expired before the tests finished");
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_tests.txt ====
# pc4 addr rs2 imm_u rd rw dren dwen width wsel ifence sfence rdata busy err delay, then expected:
# wdata byte_en ren wen exc(mal_l,mal_s,fault_l,fault_s) reg_wdata reg_write
104 00001000 0 0 01 1 1 0 0 0 0 0 F1E28374 0 0 0 0 1 1 0 0 00000074 1
108 00001001 0 0 02 1 1 0 0 0 0 0 F1E28374 0 0 0 0 2 1 0 0 FFFFFF83 1
10C 00001002 0 0 03 1 1 0 0 0 0 0 F1E28374 0 0 0 0 4 1 0 0 FFFFFFE2 1
110 00001003 0 0 04 1 1 0 0 0 0 0 F1E28374 0 0 0 0 8 1 0 0 FFFFFFF1 1
114 00001004 0 0 05 1 1 0 4 0 0 0 F1E28374 0 0 0 0 1 1 0 0 00000074 1
118 00001005 0 0 06 1 1 0 4 0 0 0 F1E28374 0 0 0 0 2 1 0 0 00000083 1
11C 00001006 0 0 07 1 1 0 4 0 0 0 F1E28374 0 0 0 0 4 1 0 0 000000E2 1
120 00001007 0 0 08 1 1 0 4 0 0 0 F1E28374 0 0 0 0 8 1 0 0 000000F1 1
124 00001008 0 0 09 1 1 0 1 0 0 0 F1E28374 0 0 0 0 3 1 0 0 FFFF8374 1
128 0000100A 0 0 0A 1 1 0 1 0 0 0 F1E28374 0 0 0 0 C 1 0 0 FFFFF1E2 1
12C 0000100C 0 0 0B 1 1 0 5 0 0 0 F1E28374 0 0 0 0 3 1 0 0 00008374 1
130 0000100E 0 0 0C 1 1 0 5 0 0 0 F1E28374 0 0 0 0 C 1 0 0 0000F1E2 1
134 00001010 0 0 0D 1 1 0 2 0 0 0 F1E28374 0 0 0 0 F 1 0 0 F1E28374 1
200 00002001 A5B6C7D8 0 00 0 0 1 0 3 0 0 0 0 0 0 D8D8D8D8 2 0 1 0 00002001 0
204 00002002 A5B6C7D8 0 00 0 0 1 1 3 0 0 0 0 0 0 C7D8C7D8 C 0 1 0 00002002 0
208 00002000 A5B6C7D8 0 00 0 0 1 1 3 0 0 0 0 0 0 C7D8C7D8 3 0 1 0 00002000 0
20C 00002004 A5B6C7D8 0 00 0 0 1 2 3 0 0 0 0 0 0 A5B6C7D8 F 0 1 0 00002004 0
300 00003001 0 0 0E 1 1 0 2 0 0 0 0 0 0 0 0 0 0 0 8 00000000 0
304 00003003 0 0 0F 1 1 0 1 0 0 0 0 0 0 0 0 0 0 0 8 00000000 0
308 00003002 A5B6C7D8 0 00 0 0 1 2 3 0 0 0 0 0 0 A5B6C7D8 0 0 0 4 00003002 0
400 00004000 0 0 10 1 1 0 2 0 0 0 DEADBEEF 0 1 0 0 F 1 0 2 DEADBEEF 0
404 00004004 A5B6C7D8 0 00 0 0 1 2 3 0 0 0 0 1 0 A5B6C7D8 F 0 1 1 00004004 0
500 00005000 0 0 11 1 1 0 2 0 0 0 0BADF00D 3 0 0 0 F 1 0 0 0BADF00D 1
504 00005001 A5B6C7D8 0 00 0 0 1 0 3 0 0 0 2 0 0 D8D8D8D8 2 0 1 0 00005001 0
508 00005002 0 0 12 1 1 0 5 0 0 0 0BADF00D 1 0 0 0 C 1 0 0 00000BAD 1
600 00000000 0 0 00 0 0 0 7 3 1 0 0 0 0 3 0 0 0 0 0 00000000 0
208 00000300 0 0 13 1 0 0 7 1 0 0 0 0 0 0 0 0 0 0 0 00000208 1
604 00000000 0 0 00 0 0 0 7 3 0 1 0 0 0 0 0 0 0 0 0 00000000 0
20C 00000000 0 ABCDE000 14 1 0 0 7 2 0 0 0 0 0 0 0 0 0 0 0 ABCDE000 1
608 00000000 0 0 00 0 0 0 7 3 0 1 0 0 0 2 0 0 0 0 0 00000000 0
210 0000002A 0 0 15 1 0 0 7 3 0 0 0 0 0 0 0 0 0 0 0 0000002A 1
60C 00000000 0 0 00 0 0 0 7 3 1 0 0 0 0 1 0 0 0 0 0 00000000 0

// ==== list.f ====
mem_stage_pkg.sv
pipe_reg.sv
mem_lane_unit.sv
load_extender.sv
fence_tracker.sv
wb_select.sv
mem_pipeline_top.sv
tb_clock_gen.sv
tb_mem_pipeline.sv

// ==== Bender.yml ====
package:
  name: mem_pipeline

sources:
  - mem_stage_pkg.sv
  - pipe_reg.sv
  - mem_lane_unit.sv
  - load_extender.sv
  - fence_tracker.sv
  - wb_select.sv
  - mem_pipeline_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_mem_pipeline.sv
